// File: common/mem_pkg.sv
package mem_pkg;

  // address split: high bits pick the page/segment, low bits the word in it
  localparam int PAGE_BITS = 3;  // 8 words per page
  localparam int SEG_BITS = 4;  // 16 physical segments
  localparam int ADDR_BITS = PAGE_BITS + SEG_BITS;

  localparam int NUM_SEGS = 1 << SEG_BITS;  // mmu table entries
  localparam int RAM_WORDS = 1 << ADDR_BITS;  // program ram size

  localparam int LEN_BITS = 6;  // prog_len width, in instructions

  typedef logic [15:0] word_t;

  // logical and physical word address
  // physical is {segment, offset}, logical is {page, offset}
  typedef logic [ADDR_BITS-1:0] addr_t;

  typedef logic [SEG_BITS-1:0] seg_t;  // segment index, also used as page tag
  typedef logic [PAGE_BITS-1:0] offs_t;  // word within a page
  typedef logic [LEN_BITS-1:0] len_t;

  // fetch report characters
  localparam logic [7:0] CH_START = 8'h53;  // "S" after reset
  localparam logic [7:0] CH_DONE = 8'h44;  // "D" run complete
  localparam logic [7:0] CH_FAULT = 8'h45;  // "E" translation fault

endpackage

// File: common/uart_pkg.sv
package uart_pkg;

  typedef logic [7:0] byte_t;

  // 8N1 frame
  localparam int DATA_BITS = 8;
  localparam int STOP_BITS = 1;
  localparam int FRAME_BITS = 1 + DATA_BITS + STOP_BITS;  // start + data + stop

  // data bit state counter width
  localparam int DATA_IDX_W = $clog2(DATA_BITS);

endpackage

// File: mmu/mmu_table.sv
module mmu_table (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           cfg_we,
  input  mem_pkg::seg_t  cfg_seg,   // entry to write
  input  mem_pkg::seg_t  cfg_next,  // next segment of the chain
  input  mem_pkg::seg_t  cfg_page,  // logical page held by cfg_seg
  output mem_pkg::seg_t  chain    [mem_pkg::NUM_SEGS],
  output mem_pkg::seg_t  page_tag [mem_pkg::NUM_SEGS]
);

  // chain[i] == i marks the end of a chain
  // page_tag 0 never matches a walk, page 0 is always start_seg

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < mem_pkg::NUM_SEGS; i++) begin
        chain[i]    <= mem_pkg::seg_t'(i);  // every segment terminates
        page_tag[i] <= '0;  // empty
      end
    end else if (cfg_we) begin
      chain[cfg_seg]    <= cfg_next;
      page_tag[cfg_seg] <= cfg_page;
    end
  end

endmodule

// File: mmu/mmu_walk.sv
module mmu_walk (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           xlate_req,    // one-cycle request
  input  mem_pkg::addr_t xlate_laddr,  // held by requester until done
  input  mem_pkg::seg_t  start_seg,    // first segment of the running program
  input  mem_pkg::seg_t  chain    [mem_pkg::NUM_SEGS],
  input  mem_pkg::seg_t  page_tag [mem_pkg::NUM_SEGS],
  output logic           xlate_done,
  output mem_pkg::addr_t xlate_paddr,
  output logic           xlate_fault
);

  mem_pkg::seg_t lpage;
  mem_pkg::offs_t offset;
  mem_pkg::seg_t cur_seg;  // segment under test
  logic walking;
  logic hit;
  logic dead_end;
  logic [mem_pkg::SEG_BITS:0] steps;  // segments visited so far

  assign lpage    = xlate_laddr[mem_pkg::ADDR_BITS-1:mem_pkg::PAGE_BITS];
  assign offset   = xlate_laddr[mem_pkg::PAGE_BITS-1:0];
  assign hit      = page_tag[cur_seg] == lpage;
  assign dead_end = chain[cur_seg] == cur_seg;  // self link ends the chain

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      walking     <= 1'b0;
      xlate_done  <= 1'b0;
      xlate_fault <= 1'b0;
      steps       <= '0;
    end else begin
      xlate_done <= 1'b0;
      if (walking) begin
        steps <= steps + 1'b1;
        if (hit || dead_end) begin  // tag checked before the link
          walking     <= 1'b0;
          xlate_done  <= 1'b1;
          xlate_fault <= !hit;
        end
      end else if (xlate_req) begin
        walking     <= lpage != '0;
        xlate_done  <= lpage == '0;  // page 0 answers at once
        xlate_fault <= 1'b0;
        steps       <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (walking) begin
      cur_seg <= chain[cur_seg];
      if (hit) xlate_paddr <= {cur_seg, offset};
    end else if (xlate_req) begin
      cur_seg     <= chain[start_seg];  // first step of the walk
      xlate_paddr <= {start_seg, offset};
    end
  end

  // a loop-free chain visits each segment at most once
  a_walk_bounded: assert property (@(posedge clk) disable iff (!arst_n)
    walking |-> steps < (mem_pkg::SEG_BITS + 1)'(mem_pkg::NUM_SEGS))
    else $error("mmu walk exceeded %0d steps, chain loops", mem_pkg::NUM_SEGS);

endmodule

// File: hdl/program_ram.sv
module program_ram (
  input  logic           clk,
  input  logic           load_we,
  input  mem_pkg::addr_t load_addr,  // physical
  input  mem_pkg::word_t load_data,
  input  logic           rd_en,
  input  mem_pkg::addr_t rd_addr,    // physical
  output mem_pkg::word_t rd_data     // valid the cycle after rd_en
);

  mem_pkg::word_t mem [mem_pkg::RAM_WORDS];

  // load port, filled before a run
  always_ff @(posedge clk) begin
    if (load_we) begin
      mem[load_addr] <= load_data;
    end
  end

  // registered read, held while rd_en is low
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: hdl/fetch_ctrl.sv
module fetch_ctrl (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            start,
  input  mem_pkg::len_t   prog_len,
  input  logic            xlate_done,
  input  mem_pkg::addr_t  xlate_paddr,
  input  logic            xlate_fault,
  input  mem_pkg::word_t  rd_data,
  input  logic            full,
  output logic            busy,
  output logic            xlate_req,
  output mem_pkg::addr_t  xlate_laddr,
  output logic            rd_en,
  output mem_pkg::addr_t  rd_addr,
  output logic            push,
  output uart_pkg::byte_t push_data
);

  typedef enum logic [2:0] {S_HELLO, S_IDLE, S_XLATE, S_READ, S_REPORT, S_FINISH} state_t;

  state_t state;
  mem_pkg::len_t instr_left;  // instructions still to fetch
  logic second_word;  // operand word of the current instruction
  logic faulted;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= S_HELLO;
      busy        <= 1'b0;
      xlate_req   <= 1'b0;
      xlate_laddr <= '0;
      rd_en       <= 1'b0;
      rd_addr     <= '0;
      push        <= 1'b0;
      push_data   <= '0;
      instr_left  <= '0;
      second_word <= 1'b0;
      faulted     <= 1'b0;
    end else begin
      xlate_req <= 1'b0;  // strobes
      rd_en     <= 1'b0;
      push      <= 1'b0;
      case (state)
        S_HELLO: if (!full) begin
          push      <= 1'b1;
          push_data <= mem_pkg::CH_START;
          state     <= S_IDLE;
        end
        S_IDLE: if (start) begin  // only sampled here, so ignored while busy
          busy        <= 1'b1;
          xlate_laddr <= '0;
          instr_left  <= prog_len;
          second_word <= 1'b0;
          faulted     <= 1'b0;
          if (prog_len == '0) state <= S_FINISH;
          else begin
            xlate_req <= 1'b1;
            state     <= S_XLATE;
          end
        end
        S_XLATE: if (xlate_done) begin
          if (xlate_fault) begin
            faulted <= 1'b1;
            state   <= S_FINISH;
          end else begin
            rd_en   <= 1'b1;
            rd_addr <= xlate_paddr;
            state   <= S_READ;
          end
        end
        S_READ: begin  // ram latches the word on this edge
          if (!second_word) state <= S_REPORT;
          else begin
            second_word <= 1'b0;
            xlate_laddr <= xlate_laddr + 1'b1;
            instr_left  <= instr_left - 1'b1;
            if (instr_left == mem_pkg::len_t'(1)) state <= S_FINISH;
            else begin
              xlate_req <= 1'b1;
              state     <= S_XLATE;
            end
          end
        end
        S_REPORT: if (!full) begin  // opcode byte, then fetch the operand
          push        <= 1'b1;
          push_data   <= rd_data[15:8];
          second_word <= 1'b1;
          xlate_laddr <= xlate_laddr + 1'b1;
          xlate_req   <= 1'b1;
          state       <= S_XLATE;
        end
        S_FINISH: if (!full) begin
          push      <= 1'b1;
          push_data <= faulted ? mem_pkg::CH_FAULT : mem_pkg::CH_DONE;
          busy      <= 1'b0;
          state     <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // queue count must never overflow
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
    else $error("fetch pushed into a full uart queue");

endmodule

// File: uart/uart_char_queue.sv
module uart_char_queue #(
  parameter int QUEUE_DEPTH = 8  // power of two
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            push,
  input  uart_pkg::byte_t push_data,
  input  logic            pop,
  output logic            full,
  output logic            q_valid,
  output uart_pkg::byte_t q_data
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  uart_pkg::byte_t slots [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;  // wraps naturally
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] count;  // occupancy, 0..QUEUE_DEPTH
  logic wr;
  logic rd;

  assign wr      = push && !full;
  assign rd      = pop && q_valid;
  assign full    = count == (PTR_W + 1)'(QUEUE_DEPTH);
  assign q_valid = count != '0;
  assign q_data  = slots[rd_ptr];  // head byte

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) wr_ptr <= wr_ptr + 1'b1;
      if (rd) rd_ptr <= rd_ptr + 1'b1;
      case ({wr, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none, or both at once
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr) slots[wr_ptr] <= push_data;
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) pop |-> q_valid)
    else $error("uart transmitter popped an empty queue");

endmodule

// File: uart/uart_tx.sv
module uart_tx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            q_valid,
  input  uart_pkg::byte_t q_data,
  output logic            pop,  // byte taken this cycle
  output logic            tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

  state_t state;
  logic [CNT_W-1:0] clk_cnt;  // clocks left in the current bit
  logic [uart_pkg::DATA_IDX_W-1:0] bit_idx;
  uart_pkg::byte_t shreg;  // lsb goes out first
  logic bit_end;

  assign bit_end = clk_cnt == '0;
  assign pop     = (state == S_IDLE) && q_valid;

  always_comb begin
    case (state)
      S_START: tx = 1'b0;
      S_DATA:  tx = shreg[0];
      default: tx = 1'b1;  // idle and stop are mark
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= S_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else if (state == S_IDLE) begin
      if (q_valid) begin
        state   <= S_START;
        clk_cnt <= RELOAD;
      end
    end else if (!bit_end) begin
      clk_cnt <= clk_cnt - 1'b1;
    end else begin
      clk_cnt <= RELOAD;
      case (state)
        S_START: begin
          state   <= S_DATA;
          bit_idx <= '0;
        end
        S_DATA: begin
          if (bit_idx == uart_pkg::DATA_IDX_W'(uart_pkg::DATA_BITS - 1)) state <= S_STOP;
          else bit_idx <= bit_idx + 1'b1;
        end
        default: state <= S_IDLE;  // stop bit done
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) shreg <= q_data;
    else if (state == S_DATA && bit_end) shreg <= shreg >> 1;
  end

endmodule

// File: hdl/fetch_top.sv
module fetch_top #(
  parameter int CLKS_PER_BIT = 8,
  parameter int QUEUE_DEPTH  = 8
) (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           start,
  input  mem_pkg::len_t  prog_len,   // instructions
  input  mem_pkg::seg_t  start_seg,  // keep stable during a run
  input  logic           cfg_we,
  input  mem_pkg::seg_t  cfg_seg,
  input  mem_pkg::seg_t  cfg_next,
  input  mem_pkg::seg_t  cfg_page,
  input  logic           load_we,
  input  mem_pkg::addr_t load_addr,  // physical
  input  mem_pkg::word_t load_data,
  output logic           tx,
  output logic           busy
);

  mem_pkg::seg_t chain [mem_pkg::NUM_SEGS];
  mem_pkg::seg_t page_tag [mem_pkg::NUM_SEGS];
  logic xlate_req, xlate_done, xlate_fault;
  mem_pkg::addr_t xlate_laddr, xlate_paddr;
  logic rd_en;
  mem_pkg::addr_t rd_addr;
  mem_pkg::word_t rd_data;
  logic push, full, q_valid, pop;
  uart_pkg::byte_t push_data, q_data;

  mmu_table i_mmu_table (.clk, .arst_n, .cfg_we, .cfg_seg, .cfg_next, .cfg_page,
                         .chain, .page_tag);

  mmu_walk i_mmu_walk (.clk, .arst_n, .xlate_req, .xlate_laddr, .start_seg, .chain,
                       .page_tag, .xlate_done, .xlate_paddr, .xlate_fault);

  program_ram i_program_ram (.clk, .load_we, .load_addr, .load_data, .rd_en, .rd_addr,
                             .rd_data);

  fetch_ctrl i_fetch_ctrl (.clk, .arst_n, .start, .prog_len, .xlate_done, .xlate_paddr,
                           .xlate_fault, .rd_data, .full, .busy, .xlate_req, .xlate_laddr,
                           .rd_en, .rd_addr, .push, .push_data);

  uart_char_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_uart_char_queue (
    .clk, .arst_n, .push, .push_data, .pop, .full, .q_valid, .q_data);

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (.clk, .arst_n, .q_valid, .q_data, .pop, .tx);

endmodule

// File: bench/tb_fetch_top.sv
module tb_fetch_top;

  localparam int CLKS_PER_BIT = 8;
  localparam int QUEUE_DEPTH = 8;
  localparam int FRAME_CYCLES = uart_pkg::FRAME_BITS * CLKS_PER_BIT;

  // watchdog budget covers every received byte, idle checks, walks and setup, then doubled
  localparam int RX_BYTES = 54;  // 1 + 5 + 13 + 13 + 17 + 5
  localparam int IDLE_FRAMES = 2;
  localparam int WALK_CYCLES = 52 * 2 * (mem_pkg::NUM_SEGS + 6);  // 52 instructions
  localparam int SETUP_CYCLES = 5 + mem_pkg::RAM_WORDS + 16;
  localparam int CYCLE_LIMIT =
    2 * ((RX_BYTES + IDLE_FRAMES) * FRAME_CYCLES + WALK_CYCLES + SETUP_CYCLES);

  logic clk, arst_n, start, cfg_we, load_we;
  mem_pkg::len_t prog_len;
  mem_pkg::seg_t start_seg, cfg_seg, cfg_next, cfg_page;
  mem_pkg::addr_t load_addr;
  mem_pkg::word_t load_data;
  logic tx, busy;

  mem_pkg::word_t ram_model [mem_pkg::RAM_WORDS];  // copy of what was loaded
  mem_pkg::seg_t chain_model [mem_pkg::NUM_SEGS];
  mem_pkg::seg_t tag_model [mem_pkg::NUM_SEGS];
  uart_pkg::byte_t exp_q [$];  // bytes the next run should send
  logic [31:0] rng;
  int cycles = 0;

  fetch_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .QUEUE_DEPTH(QUEUE_DEPTH)) i_dut (
    .clk, .arst_n, .start, .prog_len, .start_seg, .cfg_we, .cfg_seg, .cfg_next, .cfg_page,
    .load_we, .load_addr, .load_data, .tx, .busy);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) stop_fail($sformatf("run timed out after %0d cycles", cycles));
  end

  task automatic stop_fail(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_byte(input string name, input uart_pkg::byte_t exp,
                            input uart_pkg::byte_t act);
    assert (act === exp)
    else stop_fail($sformatf("ERROR %s: expected 8'h%02h, actual 8'h%02h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input string what, input logic exp,
                           input logic act);
    assert (act === exp)
    else stop_fail($sformatf("ERROR %s: %s expected %0b, actual %0b", name, what, exp, act));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // all driving tasks start and end on a falling edge
  task automatic load_word(input mem_pkg::addr_t addr, input mem_pkg::word_t data);
    load_we   = 1'b1;
    load_addr = addr;
    load_data = data;
    ram_model[addr] = data;
    @(negedge clk);
    load_we = 1'b0;
  endtask

  task automatic cfg_segment(input mem_pkg::seg_t seg, input mem_pkg::seg_t next,
                             input mem_pkg::seg_t page);
    cfg_we   = 1'b1;
    cfg_seg  = seg;
    cfg_next = next;
    cfg_page = page;
    chain_model[seg] = next;
    tag_model[seg]   = page;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  // random opcode in the high byte, address in the low byte
  task automatic fill_ram();
    for (int a = 0; a < mem_pkg::RAM_WORDS; a++) begin
      rng = xorshift(rng);
      load_word(mem_pkg::addr_t'(a), {rng[15:8], 1'b0, mem_pkg::addr_t'(a)});
    end
  endtask

  // reference chain walk returning 1 on a fault
  function automatic bit walk_model(input mem_pkg::addr_t laddr, input mem_pkg::seg_t sseg,
                                    output mem_pkg::addr_t paddr);
    mem_pkg::seg_t page;
    mem_pkg::seg_t seg;
    page  = laddr[mem_pkg::ADDR_BITS-1:mem_pkg::PAGE_BITS];
    paddr = {sseg, laddr[mem_pkg::PAGE_BITS-1:0]};
    if (page == '0) return 1'b0;  // page 0 is the start segment
    seg = chain_model[sseg];
    for (int n = 0; n < mem_pkg::NUM_SEGS; n++) begin
      if (tag_model[seg] == page) begin  // tag wins over a self link
        paddr = {seg, laddr[mem_pkg::PAGE_BITS-1:0]};
        return 1'b0;
      end
      if (chain_model[seg] == seg) return 1'b1;
      seg = chain_model[seg];
    end
    return 1'b1;
  endfunction

  task automatic build_expected(input mem_pkg::len_t len, input mem_pkg::seg_t sseg);
    mem_pkg::addr_t paddr;
    exp_q.delete();
    for (int i = 0; i < len; i++) begin
      if (walk_model(mem_pkg::addr_t'(2 * i), sseg, paddr)) begin
        exp_q.push_back(mem_pkg::CH_FAULT);
        return;
      end
      exp_q.push_back(ram_model[paddr][15:8]);  // opcode byte
      if (walk_model(mem_pkg::addr_t'(2 * i + 1), sseg, paddr)) begin
        exp_q.push_back(mem_pkg::CH_FAULT);
        return;
      end
    end
    exp_q.push_back(mem_pkg::CH_DONE);
  endtask

  // uart receiver sampling each bit near its middle
  task automatic receive_byte(input string name, output uart_pkg::byte_t b);
    uart_pkg::byte_t data;
    while (tx !== 1'b0) @(negedge clk);  // start bit edge
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    check_bit(name, "start bit", 1'b0, tx);
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data[i] = tx;  // lsb first
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    check_bit(name, "stop bit", 1'b1, tx);
    b = data;
  endtask

  task automatic run_program(input string name, input mem_pkg::len_t len,
                             input mem_pkg::seg_t sseg, input bit extra_start);
    uart_pkg::byte_t got;
    uart_pkg::byte_t exp;
    build_expected(len, sseg);
    prog_len  = len;
    start_seg = sseg;  // held for the whole run
    start     = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_bit(name, "busy after start", 1'b1, busy);
    if (extra_start) begin  // second pulse once the first opcode is on the line
      while (tx !== 1'b0) @(negedge clk);
      check_bit(name, "busy before second start", 1'b1, busy);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    while (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      receive_byte(name, got);
      check_byte(name, exp, got);
    end
    check_bit(name, "busy after last byte", 1'b0, busy);
  endtask

  task automatic reset_banner();
    uart_pkg::byte_t got;
    receive_byte("reset_banner", got);
    check_byte("reset_banner", mem_pkg::CH_START, got);
    check_bit("reset_banner", "busy", 1'b0, busy);
  endtask

  task automatic identity_run();
    run_program("identity_run", 6'd4, 4'd0, 1'b0);  // words 0..7 in page 0 only
  endtask

  task automatic chained_pages();
    cfg_segment(4'd0, 4'd5, 4'd0);  // 0 -> 5 -> 2
    cfg_segment(4'd5, 4'd2, 4'd1);
    cfg_segment(4'd2, 4'd2, 4'd2);  // end of chain
    run_program("chained_pages", 6'd12, 4'd0, 1'b0);
  endtask

  task automatic fault_stop();
    run_program("fault_stop", 6'd16, 4'd0, 1'b0);  // page 3 not in the chain
  endtask

  // 17 bytes against an 8 byte queue with tags out of chain order
  task automatic backpressure_run();
    cfg_segment(4'd9, 4'd12, 4'd0);
    cfg_segment(4'd12, 4'd3, 4'd2);
    cfg_segment(4'd3, 4'd6, 4'd1);
    cfg_segment(4'd6, 4'd6, 4'd3);
    run_program("backpressure_run", 6'd16, 4'd9, 1'b0);
  endtask

  task automatic ignored_restart();
    run_program("ignored_restart", 6'd4, 4'd0, 1'b1);
    repeat (IDLE_FRAMES * FRAME_CYCLES) begin  // line must stay quiet
      @(negedge clk);
      check_bit("ignored_restart", "tx idle", 1'b1, tx);
      check_bit("ignored_restart", "busy", 1'b0, busy);
    end
  endtask

  initial begin
    arst_n    = 1'b0;
    start     = 1'b0;
    prog_len  = '0;
    start_seg = '0;
    cfg_we    = 1'b0;
    cfg_seg   = '0;
    cfg_next  = '0;
    cfg_page  = '0;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    rng       = 32'haca0_cfb9;
    for (int i = 0; i < mem_pkg::NUM_SEGS; i++) begin
      chain_model[i] = mem_pkg::seg_t'(i);  // reset table has all self links
      tag_model[i]   = '0;
    end
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    reset_banner();
    fill_ram();
    identity_run();
    chained_pages();
    fault_stop();
    backpressure_run();
    ignored_restart();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: verilog.f
common/mem_pkg.sv
common/uart_pkg.sv
mmu/mmu_table.sv
mmu/mmu_walk.sv
hdl/program_ram.sv
hdl/fetch_ctrl.sv
uart/uart_char_queue.sv
uart/uart_tx.sv
hdl/fetch_top.sv
bench/tb_fetch_top.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_fetch_top \
  -o tb_fetch_top > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_fetch_top > sim.log 2>&1 ; cat sim.log
grep -qx "Simulation finished: PASS" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
